//--- vlog.f
logic/ds_pkg.sv
logic/ds_bit_phy.sv
logic/ds_byte_engine.sv
logic/ds_temp_seq.sv
logic/ds_temp_top.sv
tb/ds_sensor_model.sv
tb/tb_ds_temp_top.sv

//--- tb/tb_ds_temp_top.sv
`timescale 1ns/1ps

module tb_ds_temp_top;

    import ds_pkg::*;

    localparam int unsigned CLK_PER_US   = 2;
    localparam int unsigned CONV_WAIT_US = 50;
    localparam int unsigned CREDITS      = 2;
    // two resets, 48 bit slots and the wait, plus engine overhead
    localparam int unsigned MEAS_CYC  = (2000 + 48 * 62 + CONV_WAIT_US) * CLK_PER_US + 400;
    localparam int unsigned N_ENTRIES = 8;

    typedef struct packed {
        logic [15:0] temp;
        logic        present;
        logic [3:0]  hold_meas;     // credit held for this many measurements, 0 for a short hold
        logic        starved;       // sample only comes after a withheld credit returns
    } entry_t;

    localparam entry_t TABLE [N_ENTRIES] = '{
        '{16'h0191, 1'b1, 4'd3, 1'b0},
        '{16'hFF5E, 1'b1, 4'd6, 1'b0},
        '{16'h07D0, 1'b1, 4'd7, 1'b1},
        '{16'h0550, 1'b1, 4'd0, 1'b1},
        '{16'h0AA5, 1'b0, 4'd0, 1'b0},  // nobody answers the reset
        '{16'hFC90, 1'b1, 4'd0, 1'b0},
        '{16'h1234, 1'b0, 4'd0, 1'b0},
        '{16'h00A2, 1'b1, 4'd0, 1'b0}
    };

    logic            clk;
    logic            rst_n;
    logic            credit_return;
    logic            dq_in;
    logic            dq_out;
    logic            dq_out_en;
    logic            temp_valid;
    ds_temp_sample_t temp_sample;
    logic            model_pull;
    logic            model_present;
    ds_temp_t        model_temp;
    logic            cmd_err;
    logic [15:0]     cmd_cnt;
    logic [31:0]     lfsr;
    int unsigned     cycle;
    int unsigned     returns_seen;
    int unsigned     last_return;
    int unsigned     credit_due [$];

    assign dq_in = !(dq_out_en && !dq_out) && !model_pull;    // wired-AND, pulled up

    ds_temp_top #(
        .CLK_PER_US   (CLK_PER_US),
        .CONV_WAIT_US (CONV_WAIT_US),
        .CREDITS      (CREDITS)
    ) i_ds_temp_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .temp_valid    (temp_valid),
        .temp_sample   (temp_sample),
        .credit_return (credit_return),
        .dq_out        (dq_out),
        .dq_out_en     (dq_out_en),
        .dq_in         (dq_in)
    );

    ds_sensor_model #(
        .CLK_PER_US (CLK_PER_US)
    ) i_ds_sensor_model (
        .clk     (clk),
        .bus     (dq_in),
        .present (model_present),
        .temp    (model_temp),
        .pull    (model_pull),
        .cmd_err (cmd_err),
        .cmd_cnt (cmd_cnt)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else
            stop_on_error($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bus_idle();
        check_value("dq_out_en", dq_out_en, 1'b0);
        check_value("dq_out", dq_out, 1'b1);
        check_value("temp_valid", temp_valid, 1'b0);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int unsigned n, output int unsigned v);
        v = 0;
        for (int unsigned b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | lfsr[0];
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (credit_return) begin
            returns_seen = returns_seen + 1;
            last_return  = cycle;
        end
        assert (!cmd_err) else stop_on_error("the sensor model saw a command byte out of order");
    end

    // one credit_return pulse per due entry
    initial begin : credit_driver
        int unsigned k;
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            credit_return = 1'b0;
            for (k = 0; k < credit_due.size(); k++) begin
                if (credit_due[k] <= cycle) break;
            end
            if (k < credit_due.size()) begin
                credit_due.delete(k);
                credit_return = 1'b1;
            end
        end
    end

    initial begin : watchdog
        int unsigned limit;
        limit = 2 * N_ENTRIES * MEAS_CYC;
        for (int unsigned i = 0; i < N_ENTRIES; i++) begin
            limit = limit + 2 * TABLE[i].hold_meas * MEAS_CYC;
        end
        repeat (limit) @(posedge clk);
        stop_on_error($sformatf("timeout, the test did not end within %0d cycles", limit));
    end

    initial begin : stimulus
        int unsigned samples;
        int unsigned exp_cmds;
        int unsigned last_sample;
        int unsigned hold;
        int unsigned gap;
        entry_t      e;
        rst_n         = 1'b0;
        lfsr          = 32'h2659_4883;
        cycle         = 0;
        returns_seen  = 0;
        last_return   = 0;
        samples       = 0;
        exp_cmds      = 0;
        last_sample   = 0;
        model_present = TABLE[0].present;
        model_temp    = TABLE[0].temp;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_bus_idle();
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_bus_idle();

        for (int unsigned i = 0; i < N_ENTRIES; i++) begin
            e = TABLE[i];
            do begin
                @(posedge clk);
                #1;
            end while (!temp_valid);
            gap = cycle - last_sample;
            assert (CREDITS + returns_seen > samples) else
                stop_on_error($sformatf("sample %0d arrived with no credit left", i));
            check_value("temp_sample.no_device", temp_sample.no_device, !e.present);
            check_value("temp_sample.temp", temp_sample.temp, e.present ? e.temp : 16'h0000);
            if (e.present) exp_cmds = exp_cmds + 4;    // CC 44 CC BE
            check_value("cmd_cnt", cmd_cnt, exp_cmds);
            if (e.starved) begin
                assert (gap > 2 * MEAS_CYC) else
                    stop_on_error($sformatf("sample %0d came only %0d cycles after the last one",
                                            i, gap));
                assert (cycle - last_return <= MEAS_CYC) else
                    stop_on_error($sformatf("sample %0d took too long after its credit", i));
            end
            samples     = samples + 1;
            last_sample = cycle;
            if (i + 1 < N_ENTRIES) begin
                model_present = TABLE[i + 1].present;
                model_temp    = TABLE[i + 1].temp;
            end
            if (e.hold_meas == 0) begin
                draw_bits(6, hold);
                hold = hold + 1;
            end else begin
                hold = e.hold_meas * MEAS_CYC;
            end
            credit_due.push_back(cycle + hold);
        end
        $display("No errors");
        $finish;
    end

endmodule

//--- tb/ds_sensor_model.sv
`timescale 1ns/1ps

module ds_sensor_model #(
    parameter int unsigned CLK_PER_US = 2
) (
    input  logic             clk,
    input  logic             bus,
    input  logic             present,
    input  ds_pkg::ds_temp_t temp,
    output logic             pull,      // 1 holds the line low
    output logic             cmd_err,
    output logic [15:0]      cmd_cnt
);

    import ds_pkg::*;

    localparam int unsigned RESET_MIN = 480 * CLK_PER_US;
    localparam int unsigned ONE_MAX   = 30 * CLK_PER_US;   // shorter lows are ones
    localparam int unsigned PD_WAIT   = 30 * CLK_PER_US;
    localparam int unsigned PD_LEN    = 120 * CLK_PER_US;
    localparam int unsigned ZERO_LEN  = 30 * CLK_PER_US;
    localparam logic [7:0]  CMD_ORDER [4] = '{8'hCC, 8'h44, 8'hCC, 8'hBE};

    typedef enum logic [1:0] {
        P_IDLE,
        P_CMD,
        P_READ
    } phase_e;

    phase_e      phase;
    logic        prev_lvl;
    int unsigned low_cnt;
    int unsigned pull_wait;
    int unsigned pull_len;
    int unsigned bit_cnt;
    int unsigned rd_idx;
    ds_byte_t    shreg;

    task automatic take_bit(input logic b);
        logic [7:0] want;
        shreg   = {b, shreg[7:1]};   // LSB arrives first
        bit_cnt = bit_cnt + 1;
        if (bit_cnt == 8) begin
            bit_cnt = 0;
            want    = CMD_ORDER[cmd_cnt[1:0]];
            if (shreg != want) begin
                $display("sensor model got command byte %h where %h was due", shreg, want);
                cmd_err = 1'b1;
            end
            cmd_cnt = cmd_cnt + 1'b1;
            if (shreg == 8'hBE) begin
                phase  = P_READ;
                rd_idx = 0;
            end else if (shreg == 8'h44) begin
                phase = P_IDLE;     // converting until the next reset
            end
        end
    endtask

    // a low pulse from the master has just ended
    task automatic pulse_end();
        if (low_cnt > RESET_MIN) begin
            bit_cnt = 0;
            if (present) begin
                phase     = P_CMD;
                pull_wait = PD_WAIT;
                pull_len  = PD_LEN;
            end else begin
                phase = P_IDLE;
            end
        end else if (phase == P_CMD) begin
            take_bit(low_cnt < ONE_MAX);
        end
    endtask

    task automatic send_bit();
        if (!temp[rd_idx]) begin
            pull     = 1'b1;
            pull_len = ZERO_LEN;
        end
        rd_idx = rd_idx + 1;
        if (rd_idx == 16) phase = P_IDLE;
    endtask

    task automatic step_cycle();
        logic lvl;
        lvl = bus;
        if (pull_wait != 0) begin
            pull_wait = pull_wait - 1;
            if (pull_wait == 0) pull = 1'b1;
        end else if (pull_len != 0) begin
            pull_len = pull_len - 1;
            if (pull_len == 0) begin
                pull     = 1'b0;
                prev_lvl = 1'b1;
                low_cnt  = 0;
            end
        end else begin
            if (!lvl) low_cnt = low_cnt + 1;
            if (!lvl && prev_lvl && phase == P_READ) begin
                send_bit();
            end else if (lvl && !prev_lvl) begin
                pulse_end();
            end
            prev_lvl = lvl;
            if (lvl) low_cnt = 0;
        end
    endtask

    initial begin
        pull      = 1'b0;
        cmd_err   = 1'b0;
        cmd_cnt   = '0;
        phase     = P_IDLE;
        prev_lvl  = 1'b1;
        low_cnt   = 0;
        pull_wait = 0;
        pull_len  = 0;
        bit_cnt   = 0;
        rd_idx    = 0;
        shreg     = '0;
        forever begin
            @(posedge clk);
            #1;
            step_cycle();
        end
    end

endmodule

//--- logic/ds_temp_top.sv
`timescale 1ns/1ps

module ds_temp_top #(
    parameter int unsigned CLK_PER_US   = 25,
    parameter int unsigned CONV_WAIT_US = 750000,
    parameter int unsigned CREDITS      = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    temp_valid,
    output ds_pkg::ds_temp_sample_t temp_sample,
    input  logic                    credit_return,
    output logic                    dq_out,
    output logic                    dq_out_en,
    input  logic                    dq_in
);

    import ds_pkg::*;

    ds_byte_req_t byte_req;
    logic         byte_req_vld;
    logic         byte_rdy;
    logic         byte_done;
    ds_byte_t     byte_rdata;
    logic         byte_presence;

    ds_bit_req_t  bit_req;
    logic         bit_req_vld;
    logic         bit_rdy;
    logic         bit_done;
    logic         bit_rdata;
    logic         bit_presence;

    ds_temp_seq #(
        .CLK_PER_US   (CLK_PER_US),
        .CONV_WAIT_US (CONV_WAIT_US),
        .CREDITS      (CREDITS)
    ) i_ds_temp_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .temp_valid    (temp_valid),
        .temp_sample   (temp_sample),
        .credit_return (credit_return),
        .byte_req      (byte_req),
        .byte_req_vld  (byte_req_vld),
        .byte_rdy      (byte_rdy),
        .byte_done     (byte_done),
        .byte_rdata    (byte_rdata),
        .byte_presence (byte_presence)
    );

    ds_byte_engine i_ds_byte_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .byte_req      (byte_req),
        .byte_req_vld  (byte_req_vld),
        .byte_rdy      (byte_rdy),
        .byte_done     (byte_done),
        .byte_rdata    (byte_rdata),
        .byte_presence (byte_presence),
        .bit_req       (bit_req),
        .bit_req_vld   (bit_req_vld),
        .bit_rdy       (bit_rdy),
        .bit_done      (bit_done),
        .bit_rdata     (bit_rdata),
        .bit_presence  (bit_presence)
    );

    ds_bit_phy #(
        .CLK_PER_US (CLK_PER_US)
    ) i_ds_bit_phy (
        .clk          (clk),
        .rst_n        (rst_n),
        .bit_req      (bit_req),
        .bit_req_vld  (bit_req_vld),
        .bit_rdy      (bit_rdy),
        .bit_done     (bit_done),
        .bit_rdata    (bit_rdata),
        .bit_presence (bit_presence),
        .dq_out       (dq_out),
        .dq_out_en    (dq_out_en),
        .dq_in        (dq_in)
    );

endmodule

//--- logic/ds_temp_seq.sv
`timescale 1ns/1ps

module ds_temp_seq #(
    parameter int unsigned CLK_PER_US   = 25,
    parameter int unsigned CONV_WAIT_US = 750000,
    parameter int unsigned CREDITS      = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    temp_valid,
    output ds_pkg::ds_temp_sample_t temp_sample,
    input  logic                    credit_return,
    output ds_pkg::ds_byte_req_t    byte_req,
    output logic                    byte_req_vld,
    input  logic                    byte_rdy,
    input  logic                    byte_done,
    input  ds_pkg::ds_byte_t        byte_rdata,
    input  logic                    byte_presence
);

    import ds_pkg::*;

    localparam int unsigned WAIT_CYC = CONV_WAIT_US * CLK_PER_US;
    localparam int unsigned WAIT_W   = $clog2(WAIT_CYC + 1);

    typedef enum logic [3:0] {
        S_IDLE,
        S_RESET1,
        S_SKIP1,
        S_CONVERT,
        S_CONV_WAIT,
        S_RESET2,
        S_SKIP2,
        S_READ_PAD,
        S_READ_LSB,
        S_READ_MSB,
        S_EMIT
    } state_e;

    state_e            state;
    logic              issued;      // request taken, waiting for byte_done
    logic              byte_step;
    logic [WAIT_W-1:0] wait_cnt;
    ds_credit_t        credit_cnt;
    ds_temp_sample_t   sample_q;

    assign byte_step    = !(state inside {S_IDLE, S_CONV_WAIT, S_EMIT});
    assign byte_req_vld = byte_step && !issued;
    assign temp_valid   = (state == S_EMIT);
    assign temp_sample  = sample_q;

    // fixed transaction, one byte op per state
    always_comb begin
        byte_req.data = 8'h00;
        case (state)
            S_RESET1, S_RESET2: byte_req.op = BYTE_RESET;
            S_SKIP1, S_SKIP2: begin
                byte_req.op   = BYTE_WRITE;
                byte_req.data = CMD_SKIP_ROM;
            end
            S_CONVERT: begin
                byte_req.op   = BYTE_WRITE;
                byte_req.data = CMD_CONVERT;
            end
            S_READ_PAD: begin
                byte_req.op   = BYTE_WRITE;
                byte_req.data = CMD_READ_PAD;
            end
            default: byte_req.op = BYTE_READ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            issued <= 1'b0;
        end else begin
            if (byte_req_vld && byte_rdy) issued <= 1'b1;
            case (state)
                S_IDLE: if (credit_cnt != '0) state <= S_RESET1;
                S_CONV_WAIT: if (wait_cnt == WAIT_W'(WAIT_CYC - 1)) state <= S_RESET2;
                S_EMIT: state <= S_IDLE;
                default: begin
                    if (byte_done) begin
                        issued <= 1'b0;
                        case (state)
                            S_RESET1:   state <= byte_presence ? S_SKIP1 : S_EMIT;
                            S_SKIP1:    state <= S_CONVERT;
                            S_CONVERT:  state <= S_CONV_WAIT;
                            S_RESET2:   state <= byte_presence ? S_SKIP2 : S_EMIT;
                            S_SKIP2:    state <= S_READ_PAD;
                            S_READ_PAD: state <= S_READ_LSB;
                            S_READ_LSB: state <= S_READ_MSB;
                            default:    state <= S_EMIT;
                        endcase
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (state != S_CONV_WAIT) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            sample_q <= '0;     // temp stays 0 if the device is missing
        end else if (byte_done) begin
            case (state)
                S_RESET1, S_RESET2: sample_q.no_device <= !byte_presence;
                S_READ_LSB:         sample_q.temp[7:0] <= byte_rdata;
                S_READ_MSB:         sample_q.temp[15:8] <= byte_rdata;
                default:            sample_q <= sample_q;
            endcase
        end
    end

    // one credit per sample handed out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= ds_credit_t'(CREDITS);
        end else begin
            case ({temp_valid, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    a_credit_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        credit_cnt <= ds_credit_t'(CREDITS)
    );

    a_no_sample_without_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        temp_valid |-> credit_cnt != '0
    );

endmodule

//--- logic/ds_byte_engine.sv
`timescale 1ns/1ps

module ds_byte_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ds_pkg::ds_byte_req_t byte_req,
    input  logic                 byte_req_vld,
    output logic                 byte_rdy,
    output logic                 byte_done,
    output ds_pkg::ds_byte_t     byte_rdata,
    output logic                 byte_presence,
    output ds_pkg::ds_bit_req_t  bit_req,
    output logic                 bit_req_vld,
    input  logic                 bit_rdy,
    input  logic                 bit_done,
    input  logic                 bit_rdata,
    input  logic                 bit_presence
);

    import ds_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT,
        S_DONE
    } state_e;

    state_e      state;
    logic [2:0]  bit_idx;
    ds_byte_op_e op_q;
    ds_byte_t    shreg;
    logic        presence_q;
    logic        last_bit;

    assign byte_rdy      = (state == S_IDLE);
    assign byte_done     = (state == S_DONE);
    assign byte_rdata    = shreg;
    assign byte_presence = presence_q;
    assign bit_req_vld   = (state == S_ISSUE);
    assign last_bit      = (op_q == BYTE_RESET) || (bit_idx == 3'd7);

    always_comb begin
        case (op_q)
            BYTE_RESET: bit_req.op = BIT_RESET;
            BYTE_READ:  bit_req.op = BIT_READ;
            default:    bit_req.op = BIT_WRITE;
        endcase
        bit_req.wbit = shreg[0];    // LSB goes out first
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (byte_req_vld) begin
                        state   <= S_ISSUE;
                        bit_idx <= '0;
                    end
                end
                S_ISSUE: if (bit_rdy) state <= S_WAIT;
                S_WAIT: begin
                    if (bit_done) begin
                        if (last_bit) begin
                            state <= S_DONE;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            state   <= S_ISSUE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && byte_req_vld) begin
            op_q  <= byte_req.op;
            shreg <= byte_req.data;
        end else if (state == S_WAIT && bit_done) begin
            if (op_q == BYTE_RESET) begin
                presence_q <= bit_presence;
            end else begin
                // read bits land at the top and walk down to bit 0
                shreg <= {(op_q == BYTE_READ) ? bit_rdata : 1'b0, shreg[7:1]};
            end
        end
    end

    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        byte_req_vld |-> byte_rdy
    );

endmodule

//--- logic/ds_bit_phy.sv
`timescale 1ns/1ps

module ds_bit_phy #(
    parameter int unsigned CLK_PER_US = 25
) (
    input  logic                clk,
    input  logic                rst_n,
    input  ds_pkg::ds_bit_req_t bit_req,
    input  logic                bit_req_vld,
    output logic                bit_rdy,
    output logic                bit_done,
    output logic                bit_rdata,
    output logic                bit_presence,
    output logic                dq_out,
    output logic                dq_out_en,
    input  logic                dq_in
);

    import ds_pkg::*;

    // slot timing points in clocks
    localparam int unsigned T_RESET    = 1000 * CLK_PER_US;
    localparam int unsigned T_PULL     = 750 * CLK_PER_US;
    localparam int unsigned T_PRESENCE = 820 * CLK_PER_US;
    localparam int unsigned T_SLOT     = 62 * CLK_PER_US;
    localparam int unsigned T_W_LOW    = 15 * CLK_PER_US;
    localparam int unsigned T_W_END    = 60 * CLK_PER_US;
    localparam int unsigned T_RD_LOW   = 1 * CLK_PER_US;
    localparam int unsigned T_RD_SMP   = 14 * CLK_PER_US;
    localparam int unsigned CNT_W      = $clog2(T_RESET + 1);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] slot_len;
    logic             busy;
    logic             accept;
    logic             end_slot;
    ds_bit_req_t      req_q;

    assign accept   = bit_req_vld && bit_rdy;
    assign bit_rdy  = !busy;
    assign end_slot = busy && (cnt == slot_len - 1'b1);
    assign bit_done = end_slot;

    // one counter shared by all slot kinds
    always_comb begin
        case (req_q.op)
            BIT_RESET: slot_len = CNT_W'(T_RESET);
            default:   slot_len = CNT_W'(T_SLOT);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (end_slot) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= bit_req;
        end
    end

    // every slot opens with the line pulled low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dq_out    <= 1'b1;
            dq_out_en <= 1'b0;
        end else if (accept) begin
            dq_out    <= 1'b0;
            dq_out_en <= 1'b1;
        end else if (busy) begin
            case (req_q.op)
                BIT_RESET: begin
                    if (cnt == CNT_W'(T_PULL - 1)) begin
                        dq_out    <= 1'b1;
                        dq_out_en <= 1'b0;  // release, device may answer
                    end
                end
                BIT_WRITE: begin
                    if (cnt == CNT_W'(T_W_LOW - 1)) begin
                        dq_out <= req_q.wbit;
                    end else if (cnt == CNT_W'(T_W_END - 1)) begin
                        dq_out    <= 1'b1;
                        dq_out_en <= 1'b0;
                    end
                end
                BIT_READ: begin
                    if (cnt == CNT_W'(T_RD_LOW - 1)) begin
                        dq_out    <= 1'b1;
                        dq_out_en <= 1'b0;
                    end
                end
                default: begin
                    dq_out    <= 1'b1;
                    dq_out_en <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (busy && req_q.op == BIT_READ && cnt == CNT_W'(T_RD_SMP - 1)) begin
            bit_rdata <= dq_in;
        end
        // device holds the line low during its presence pulse
        if (busy && req_q.op == BIT_RESET && cnt == CNT_W'(T_PRESENCE - 1)) begin
            bit_presence <= !dq_in;
        end
    end

    // the byte engine must wait for the previous slot to finish
    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        bit_req_vld |-> bit_rdy
    );

endmodule

//--- logic/ds_pkg.sv
package ds_pkg;

    // kinds of one-wire bit slot
    typedef enum logic [1:0] {
        BIT_RESET,
        BIT_WRITE,
        BIT_READ
    } ds_bit_op_e;

    typedef struct packed {
        ds_bit_op_e op;
        logic       wbit;   // level driven after the 15us low
    } ds_bit_req_t;

    // byte-level operations seen by the sequencer
    typedef enum logic [1:0] {
        BYTE_RESET,
        BYTE_WRITE,
        BYTE_READ
    } ds_byte_op_e;

    typedef logic [7:0] ds_byte_t;

    typedef struct packed {
        ds_byte_op_e op;
        ds_byte_t    data;  // ignored for reset and read
    } ds_byte_req_t;

    // scratchpad bytes 1:0, MSB byte on top
    typedef logic [15:0] ds_temp_t;

    typedef struct packed {
        ds_temp_t temp;
        logic     no_device;
    } ds_temp_sample_t;

    typedef logic [3:0] ds_credit_t;

    // function commands, single device on the bus
    localparam ds_byte_t CMD_SKIP_ROM = 8'hCC;
    localparam ds_byte_t CMD_CONVERT  = 8'h44;
    localparam ds_byte_t CMD_READ_PAD = 8'hBE;

endpackage
